//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // addi x0, x0, 0
    localparam word_t I_NOP = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Source of ALU operand A
    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_PC   = 2'd1,
        A_ZERO = 2'd2
    } a_src_e;

    // Control bits, cleared by reset and by flush
    typedef struct packed {
        logic reg_write;
        logic is_branch;
        logic is_jump;
    } id_ctrl_t;

    // Decoded fields, cleared by flush only
    typedef struct packed {
        a_src_e   alu_a_src;
        logic     alu_b_imm;
        alu_op_e  alu_op;
        logic     res_pc4;
        logic [2:0] funct3;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    instr;
    } id_dec_t;

    // Operand data, no reset
    typedef struct packed {
        word_t rs1_data;
        word_t rs2_data;
        word_t imm;
        word_t pc;
        word_t pc_plus4;
    } id_data_t;

    // Writeback record leaving EX
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- rtl/rv_reg_file.sv
`timescale 1ns/10ps

module rv_reg_file
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_t      wb
);

    // x0 is not stored
    word_t regs [1:31];
    logic  wr_en;

    // Writes are blocked while reset is asserted
    assign wr_en = rst_n && wb.valid && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write is bypassed onto the read ports
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic     instr_valid,
    input  word_t    instr,
    input  word_t    pc,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output id_ctrl_t ctrl,
    output id_dec_t  dec,
    output id_data_t data
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm;
    logic       known;

    // Map funct3 and the alternate bit onto an ALU operation
    function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7_5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        known         = 1'b1;
        imm           = imm_i;
        ctrl          = '0;
        dec           = '0;
        dec.alu_a_src = A_RS1;
        dec.funct3    = funct3;
        dec.rd        = rd;
        dec.rs1       = rs1;
        dec.rs2       = rs2;
        dec.instr     = instr;

        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                dec.alu_op     = alu_map(funct3, funct7_5);
            end
            OPC_OP_IMM: begin
                // Only shifts use bit 30; addi has no subtract form
                ctrl.reg_write = 1'b1;
                dec.alu_b_imm  = 1'b1;
                dec.alu_op     = alu_map(funct3, funct7_5 && funct3 == F3_SRL_SRA);
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                dec.alu_a_src  = A_ZERO;
                dec.alu_b_imm  = 1'b1;
                dec.alu_op     = ALU_PASS_B;
                imm            = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                dec.alu_a_src  = A_PC;
                dec.alu_b_imm  = 1'b1;
                dec.alu_op     = ALU_ADD;
                imm            = imm_u;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
                dec.res_pc4    = 1'b1;
                imm            = imm_j;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                dec.alu_op     = ALU_SUB;
                imm            = imm_b;
                // Unsigned compares are not supported
                if (!(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE})) begin
                    known = 1'b0;
                end
            end
            default: known = 1'b0;
        endcase

        if (!instr_valid || !known) begin
            ctrl = '0;
        end
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign data = '{
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm,
        pc:       pc,
        pc_plus4: pc + 32'd4
    };

endmodule

//--- rtl/rv_reg_id_ex.sv
`timescale 1ns/10ps

module rv_reg_id_ex
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  id_ctrl_t ctrl_id,
    input  id_dec_t  dec_id,
    input  id_data_t data_id,
    output id_ctrl_t ctrl_ex,
    output id_dec_t  dec_ex,
    output id_data_t data_ex
);

    // Control bits, reset or flush make a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ctrl_ex <= '0;
        end else if (!stall) begin
            ctrl_ex <= ctrl_id;
        end
    end

    // Decoded fields, a flushed slot carries a NOP
    always_ff @(posedge clk) begin
        if (flush) begin
            dec_ex       <= '0;
            dec_ex.instr <= I_NOP;
        end else if (!stall) begin
            dec_ex <= dec_id;
        end
    end

    // Operand data
    always_ff @(posedge clk) begin
        if (!stall) begin
            data_ex <= data_id;
        end
    end

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/10ps

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  id_ctrl_t ctrl,
    input  id_dec_t  dec,
    input  id_data_t data,
    output logic     redirect,
    output word_t    redirect_pc,
    output wb_t      wb
);

    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_y;
    word_t    result;
    logic     br_taken;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Forward the writeback register onto matching sources
    assign rs1_fwd = (wb.valid && wb.rd != '0 && wb.rd == dec.rs1) ? wb.data : data.rs1_data;
    assign rs2_fwd = (wb.valid && wb.rd != '0 && wb.rd == dec.rs2) ? wb.data : data.rs2_data;

    always_comb begin
        case (dec.alu_a_src)
            A_PC:    alu_a = data.pc;
            A_ZERO:  alu_a = '0;
            default: alu_a = rs1_fwd;
        endcase
    end

    assign alu_b = dec.alu_b_imm ? data.imm : rs2_fwd;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_y = alu_a + alu_b;
            ALU_SUB:    alu_y = alu_a - alu_b;
            ALU_AND:    alu_y = alu_a & alu_b;
            ALU_OR:     alu_y = alu_a | alu_b;
            ALU_XOR:    alu_y = alu_a ^ alu_b;
            ALU_SLT:    alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_y = {31'b0, alu_a < alu_b};
            ALU_SLL:    alu_y = alu_a << alu_b[4:0];
            ALU_SRL:    alu_y = alu_a >> alu_b[4:0];
            ALU_SRA:    alu_y = $signed(alu_a) >>> alu_b[4:0];
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = '0;
        endcase
    end

    // Branch compare on the forwarded register values
    always_comb begin
        case (dec.funct3)
            F3_BEQ:  br_taken = (rs1_fwd == rs2_fwd);
            F3_BNE:  br_taken = (rs1_fwd != rs2_fwd);
            F3_BLT:  br_taken = ($signed(rs1_fwd) < $signed(rs2_fwd));
            F3_BGE:  br_taken = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect    = !stall && (ctrl.is_jump || (ctrl.is_branch && br_taken));
    assign redirect_pc = data.pc + data.imm;

    // JAL links pc+4
    assign result = dec.res_pc4 ? data.pc_plus4 : alu_y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd   <= dec.rd;
            wb_data <= result;
        end
    end

    assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  instr_valid,
    input  logic  stall,
    input  word_t instr,
    input  word_t pc,
    output logic  redirect,
    output word_t redirect_pc,
    output wb_t   wb
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    id_ctrl_t ctrl_id;
    id_dec_t  dec_id;
    id_data_t data_id;
    id_ctrl_t ctrl_ex;
    id_dec_t  dec_ex;
    id_data_t data_ex;

    rv_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ctrl        (ctrl_id),
        .dec         (dec_id),
        .data        (data_id)
    );

    rv_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // A taken transfer in EX squashes the instruction leaving ID
    rv_reg_id_ex u_reg_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .flush   (redirect),
        .ctrl_id (ctrl_id),
        .dec_id  (dec_id),
        .data_id (data_id),
        .ctrl_ex (ctrl_ex),
        .dec_ex  (dec_ex),
        .data_ex (data_ex)
    );

    rv_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .ctrl        (ctrl_ex),
        .dec         (dec_ex),
        .data        (data_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

endmodule

//--- test/rv_core_assertions.sv
`timescale 1ns/10ps

module rv_core_assertions
    import rv_pipe_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic redirect,
    input wb_t  wb
);

    // A taken transfer flushes ID/EX, so EX holds a bubble in the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) redirect |=> !redirect)
        else $error("redirect high in the cycle after a taken transfer");

    // The writeback register holds under stall
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(wb))
        else $error("wb changed while stall was high");

    // Reset clears the writeback valid and the control reaching EX
    assert property (@(posedge clk) !rst_n |=> (!wb.valid && !redirect))
        else $error("wb.valid or redirect high after reset");

endmodule

bind rv_execute rv_core_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .wb       (wb)
);

//--- test/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    logic  clk;
    logic  rst_n;
    logic  instr_valid;
    logic  stall;
    word_t instr;
    word_t pc;
    logic  redirect;
    word_t redirect_pc;
    wb_t   wb;

    int errors;
    int tests_passed;
    int tests_failed;
    int cycles;
    int cycle_limit;

    // Parsed stimulus, flat lists indexed per test
    string names[$];
    int    p_first[$];
    int    p_num[$];
    int    w_first[$];
    int    w_num[$];
    int    r_first[$];
    int    r_num[$];
    word_t p_addr[$];
    word_t p_word[$];
    wb_t   exp_wb[$];
    word_t exp_target[$];

    rv_core_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .stall       (stall),
        .instr       (instr),
        .pc          (pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

    always #50 clk = ~clk;

    // Watchdog on cycles after reset
    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("Timeout after %0d cycles, a test did not finish", cycles);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected x%0d=%h, actual valid=%0b x%0d=%h",
                     name, exp.rd, exp.data, act.valid, act.rd, act.data);
        end
    endtask

    task automatic check_redirect(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected redirect to %h, actual %h", name, exp, act);
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    code;
        int    rd;
        word_t a;
        word_t w;
        string tag;
        string nm;
        string line_s;
        fd = $fopen("test/rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                case (tag)
                    "#": code = $fgets(line_s, fd);
                    "T": begin
                        code = $fscanf(fd, "%s", nm);
                        names.push_back(nm);
                        p_first.push_back(p_addr.size());
                        w_first.push_back(exp_wb.size());
                        r_first.push_back(exp_target.size());
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h", a, w);
                        p_addr.push_back(a);
                        p_word.push_back(w);
                    end
                    "W": begin
                        code = $fscanf(fd, "%d %h", rd, w);
                        exp_wb.push_back('{valid: 1'b1, rd: rd[4:0], data: w});
                    end
                    "R": begin
                        code = $fscanf(fd, "%h", a);
                        exp_target.push_back(a);
                    end
                    "E": begin
                        p_num.push_back(p_addr.size() - p_first[$]);
                        w_num.push_back(exp_wb.size() - w_first[$]);
                        r_num.push_back(exp_target.size() - r_first[$]);
                    end
                    default: begin
                        errors++;
                        $display("Stimulus file has an unknown line tag %s", tag);
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // Acts as fetch for one test and checks what retires
    task automatic run_test(input int t);
        word_t prog[word_t];
        word_t fetch_pc;
        word_t target;
        int    wi;
        int    ri;
        int    idle;
        int    err0;
        logic  first;
        logic  held;
        logic  took;
        err0 = errors;
        for (int i = 0; i < p_num[t]; i++) begin
            prog[p_addr[p_first[t] + i]] = p_word[p_first[t] + i];
        end
        fetch_pc = '0;
        target   = '0;
        first    = 1'b1;
        held     = 1'b0;
        took     = 1'b0;
        wi       = 0;
        ri       = 0;
        idle     = 0;
        while (!(idle >= 3 && wi >= w_num[t] && ri >= r_num[t]) && idle < 8) begin
            @(negedge clk);
            if (!held) begin
                if (took) begin
                    fetch_pc = target;
                end else if (!first) begin
                    fetch_pc = fetch_pc + 4;
                end
                first       = 1'b0;
                instr_valid = prog.exists(fetch_pc);
                instr       = prog.exists(fetch_pc) ? prog[fetch_pc] : I_NOP;
                pc          = fetch_pc;
            end
            stall = ($urandom % 5) == 0;
            // Sample just before the rising edge
            #40;
            held = stall;
            took = 1'b0;
            if (!stall) begin
                if (wb.valid) begin
                    if (wi < w_num[t]) begin
                        check_wb(names[t], exp_wb[w_first[t] + wi], wb);
                    end else begin
                        errors++;
                        $display("Test %s: extra writeback to x%0d", names[t], wb.rd);
                    end
                    wi++;
                end
                if (redirect) begin
                    if (ri < r_num[t]) begin
                        check_redirect(names[t], exp_target[r_first[t] + ri], redirect_pc);
                    end else begin
                        errors++;
                        $display("Test %s: unexpected redirect to %h", names[t], redirect_pc);
                    end
                    ri++;
                    took   = 1'b1;
                    target = redirect_pc;
                end
                idle = prog.exists(fetch_pc) ? 0 : idle + 1;
            end
        end
        if (wi < w_num[t]) begin
            errors++;
            $display("Test %s: only %0d of %0d writebacks retired", names[t], wi, w_num[t]);
        end
        if (ri < r_num[t]) begin
            errors++;
            $display("Test %s: only %0d of %0d redirects seen", names[t], ri, r_num[t]);
        end
        if (errors == err0) begin
            tests_passed++;
            $display("Test %s: pass", names[t]);
        end else begin
            tests_failed++;
            $display("Test %s: fail", names[t]);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        stall        = 1'b0;
        instr        = I_NOP;
        pc           = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        cycle_limit  = 100;
        void'($urandom(31792));
        load_stimulus();
        cycle_limit = 4 * p_addr.size() + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (names[t]) begin
            run_test(t);
        end
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- test/rv_core_stimulus.txt
# T name | P addr instr | W rd value | R redirect_target | E ends a test
# addresses, instructions, values and targets in hex, rd in decimal
T alu_ops
P 00 00500093
P 04 FFD00113
P 08 002081B3
P 0C 40208233
P 10 0020C2B3
P 14 00112333
P 18 001133B3
P 1C 40115413
P 20 01C15493
P 24 00409513
P 28 0F017593
P 2C 1000E613
P 30 123456B7
P 34 00001717
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 00000008
W 5 FFFFFFF8
W 6 00000001
W 7 00000000
W 8 FFFFFFFE
W 9 0000000F
W 10 00000050
W 11 000000F0
W 12 00000105
W 13 12345000
W 14 00001034
E
T chain_and_x0
P 00 00100093
P 04 001080B3
P 08 001080B3
P 0C 00A08093
P 10 00700013
P 14 00100133
P 18 000001B3
W 1 00000001
W 1 00000002
W 1 00000004
W 1 0000000E
W 2 0000000E
W 3 00000000
E
T branches_jal
P 00 00300093
P 04 00300113
P 08 00208663
P 0C 06300293
P 10 06200293
P 14 00209463
P 18 0020C463
P 1C 0020D463
P 20 00100313
P 24 008003EF
P 28 00100413
P 2C FFF00493
P 30 0014C463
P 34 00100513
P 38 00008593
W 1 00000003
W 2 00000003
W 7 00000028
W 9 FFFFFFFF
W 11 00000003
R 00000014
R 00000024
R 0000002C
R 00000038
E

//--- vlog.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_reg_file.sv
rtl/rv_decoder.sv
rtl/rv_reg_id_ex.sv
rtl/rv_execute.sv
rtl/rv_core_top.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv
